// File: secv_pkg.sv
// Core-wide data width, value types and operation encodings shared with the pipeline
package secv_pkg;

    // Machine word
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;   // Register or PC value

    // Privilege levels, only machine mode is implemented
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_mode_t;

    // Follows funct3[1:0] of the Zicsr instructions
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,   // Read and write
        CSR_RS = 2'b10,   // Read and set bits
        CSR_RC = 2'b11    // Read and clear bits
    } csr_op_t;

    typedef logic [4:0] ex_cause_t;    // Exception code
    typedef logic [4:0] irq_cause_t;   // Interrupt code

endpackage

// File: csr_pkg.sv
// CSR addresses, writable field masks, interrupt vector layout and trap cause codes
package csr_pkg;

    typedef logic [11:0] csr_adr_t;

    // Machine information registers
    localparam csr_adr_t CSR_ADR_MVENDORID = 12'hF11;
    localparam csr_adr_t CSR_ADR_MARCHID   = 12'hF12;
    localparam csr_adr_t CSR_ADR_MIMPID    = 12'hF13;
    localparam csr_adr_t CSR_ADR_MHARTID   = 12'hF14;

    // Machine trap setup
    localparam csr_adr_t CSR_ADR_MSTATUS   = 12'h300;
    localparam csr_adr_t CSR_ADR_MISA      = 12'h301;
    localparam csr_adr_t CSR_ADR_MIE       = 12'h304;
    localparam csr_adr_t CSR_ADR_MTVEC     = 12'h305;

    // Machine trap handling
    localparam csr_adr_t CSR_ADR_MSCRATCH  = 12'h340;
    localparam csr_adr_t CSR_ADR_MEPC      = 12'h341;
    localparam csr_adr_t CSR_ADR_MCAUSE    = 12'h342;
    localparam csr_adr_t CSR_ADR_MTVAL     = 12'h343;
    localparam csr_adr_t CSR_ADR_MIP       = 12'h344;

    // Machine counters
    localparam csr_adr_t CSR_ADR_MCYCLE    = 12'hB00;
    localparam csr_adr_t CSR_ADR_MINSTRET  = 12'hB02;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Writable bits
    localparam secv_pkg::xlen_t MSTATUS_MASK = 64'h0000_0000_0000_0088;   // mie, mpie
    localparam secv_pkg::xlen_t MIE_MASK     = 64'h0000_0000_0000_0888;   // meie, mtie, msie
    localparam secv_pkg::xlen_t MTVEC_MASK   = 64'hFFFF_FFFF_FFFF_FFFD;   // Base plus mode bit 0

    // Machine interrupt lines, same order as in mie and mip
    typedef struct packed {
        logic mei;   // External
        logic mti;   // Timer
        logic msi;   // Software
    } ivec_t;

    // Interrupt codes, also the bit positions in mie and mip
    localparam secv_pkg::irq_cause_t IRQ_CAUSE_MSI = 5'd3;
    localparam secv_pkg::irq_cause_t IRQ_CAUSE_MTI = 5'd7;
    localparam secv_pkg::irq_cause_t IRQ_CAUSE_MEI = 5'd11;

    // Exceptions that report the faulting address in mtval
    localparam secv_pkg::ex_cause_t EX_CAUSE_LOAD_MISALIGNED   = 5'd4;
    localparam secv_pkg::ex_cause_t EX_CAUSE_LOAD_ACCESS_FAULT = 5'd5;
    localparam secv_pkg::ex_cause_t EX_CAUSE_STORE_MISALIGNED  = 5'd6;
    localparam secv_pkg::ex_cause_t EX_CAUSE_STORE_ACCESS_FAULT = 5'd7;

    // RV64 (mxl = 2), base integer ISA only
    localparam secv_pkg::xlen_t MISA_VALUE = 64'h8000_0000_0000_0100;

    // Not implemented, read as zero
    localparam secv_pkg::xlen_t MVENDORID = '0;
    localparam secv_pkg::xlen_t MARCHID   = '0;
    localparam secv_pkg::xlen_t MIMPID    = '0;

endpackage

// File: csr_if.sv
// CSR access bus and trap event interfaces with their modports
`timescale 1ns/1ps

interface csr_access_if;
    csr_pkg::csr_adr_t adr;    // Register address
    logic              we;     // Write strobe, lands on next edge
    secv_pkg::xlen_t   wdat;   // New register value
    secv_pkg::xlen_t   rdat;   // Current value, same cycle as adr
    logic              hit;    // Address decoded by this slave

    modport master (output adr, we, wdat, input rdat, hit);
    modport slave  (input adr, we, wdat, output rdat, hit);
endinterface

interface trap_if;
    logic                 take;    // Enter trap, one-cycle strobe
    logic                 intr;    // Trap is an interrupt
    secv_pkg::ex_cause_t  cause;   // Exception or interrupt code
    secv_pkg::xlen_t      pc;      // PC to save in mepc
    secv_pkg::xlen_t      tval;    // Faulting address
    logic                 mret;    // Return from trap, one-cycle strobe
    secv_pkg::xlen_t      vec;     // Trap vector for the current cause

    modport driver   (output take, intr, cause, pc, tval, mret, input vec);
    modport receiver (input take, intr, cause, pc, tval, mret, output vec);
endinterface

// File: csr_trap_fsm.sv
// Event arbiter FSM for CSR requests, exceptions, interrupts and mret with PC redirect
`timescale 1ns/1ps

module csr_trap_fsm (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 csr_req_i,
    input  logic                 ex_i,
    input  logic                 mret_i,
    input  secv_pkg::ex_cause_t  ex_cause_i,
    input  secv_pkg::xlen_t      trap_pc_i,
    input  secv_pkg::xlen_t      trap_adr_i,
    input  logic                 irq_ena_i,    // mstatus.mie
    input  csr_pkg::ivec_t       irq_vec_i,    // Pending and enabled
    output logic                 rmw_go_o,
    trap_if.driver               trap,
    output logic                 csr_done_o,
    output logic                 redirect_o,
    output secv_pkg::xlen_t      redirect_pc_o,
    input  secv_pkg::xlen_t      mepc_i
);
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        TRAP,
        RETURN
    } state_t;

    state_t state, state_nxt;
    logic   irq_take;

    assign irq_take = irq_ena_i && (|irq_vec_i);

    always_comb begin
        state_nxt  = IDLE;
        rmw_go_o   = 1'b0;
        trap.take  = 1'b0;
        trap.intr  = 1'b0;
        trap.cause = ex_cause_i;
        trap.pc    = trap_pc_i;
        trap.tval  = '0;
        trap.mret  = 1'b0;

        if (state == IDLE) begin
            if (ex_i) begin
                trap.take = 1'b1;
                trap.tval = trap_adr_i;
                state_nxt = TRAP;
            end else if (irq_take) begin
                trap.take = 1'b1;
                trap.intr = 1'b1;
                // External before software before timer
                if (irq_vec_i.mei)
                    trap.cause = csr_pkg::IRQ_CAUSE_MEI;
                else if (irq_vec_i.msi)
                    trap.cause = csr_pkg::IRQ_CAUSE_MSI;
                else
                    trap.cause = csr_pkg::IRQ_CAUSE_MTI;
                state_nxt = TRAP;
            end else if (mret_i) begin
                trap.mret = 1'b1;
                state_nxt = RETURN;
            end else if (csr_req_i) begin
                rmw_go_o  = 1'b1;
                state_nxt = ACCESS;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    // Target is captured on the accepting edge
    always_ff @(posedge clk_i) begin
        if (rst_i)
            redirect_pc_o <= '0;
        else if (trap.take)
            redirect_pc_o <= trap.vec;
        else if (trap.mret)
            redirect_pc_o <= mepc_i;
    end

    assign csr_done_o = (state == ACCESS);
    assign redirect_o = (state == TRAP) || (state == RETURN);

    a_done_redirect_excl: assert property (
        @(posedge clk_i) disable iff (rst_i) !(csr_done_o && redirect_o));

    a_busy_one_cycle: assert property (
        @(posedge clk_i) disable iff (rst_i) (state != IDLE) |=> (state == IDLE));

endmodule

// File: csr_rmw.sv
// CSR read-modify-write datapath with read data merge from the register and counter slaves
`timescale 1ns/1ps

module csr_rmw (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               go_i,
    input  secv_pkg::csr_op_t  op_i,
    input  csr_pkg::csr_adr_t  adr_i,
    input  secv_pkg::xlen_t    src_i,
    csr_access_if.master       reg_bus,
    csr_access_if.master       cnt_bus,
    output secv_pkg::xlen_t    rdata_o
);
    secv_pkg::xlen_t old_val;
    secv_pkg::xlen_t new_val;
    logic            wr_ena;

    // Old value from whichever slave decodes the address
    always_comb begin
        if (reg_bus.hit)
            old_val = reg_bus.rdat;
        else if (cnt_bus.hit)
            old_val = cnt_bus.rdat;
        else
            old_val = '0;
    end

    always_comb begin
        case (op_i)
            secv_pkg::CSR_RS: new_val = old_val | src_i;
            secv_pkg::CSR_RC: new_val = old_val & ~src_i;
            default:          new_val = src_i;
        endcase
    end

    // Set or clear with zero source does not write
    assign wr_ena = go_i && ((op_i == secv_pkg::CSR_RW) || (src_i != '0));

    assign reg_bus.adr  = adr_i;
    assign reg_bus.we   = wr_ena;
    assign reg_bus.wdat = new_val;
    assign cnt_bus.adr  = adr_i;
    assign cnt_bus.we   = wr_ena;
    assign cnt_bus.wdat = new_val;

    // Pre-write value, shown with csr_done_o
    always_ff @(posedge clk_i) begin
        if (rst_i)
            rdata_o <= '0;
        else if (go_i)
            rdata_o <= old_val;
    end

    a_single_hit: assert property (
        @(posedge clk_i) disable iff (rst_i) !(reg_bus.hit && cnt_bus.hit));

endmodule

// File: csr_regs.sv
// Machine trap setup, trap handling and information registers with trap vector logic
`timescale 1ns/1ps

module csr_regs #(
    parameter  int HARTS  = 1,
    localparam int HART_W = (HARTS > 1) ? $clog2(HARTS) : 1
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [HART_W-1:0]    hartid_i,
    input  csr_pkg::ivec_t       irq_pend_i,
    csr_access_if.slave          bus,
    trap_if.receiver             trap,
    output secv_pkg::xlen_t      mepc_o,
    output logic                 irq_ena_o,
    output csr_pkg::ivec_t       irq_vec_o
);
    secv_pkg::xlen_t mstatus;
    secv_pkg::xlen_t mie;
    secv_pkg::xlen_t mtvec;
    secv_pkg::xlen_t mscratch;
    secv_pkg::xlen_t mepc;
    secv_pkg::xlen_t mcause;
    secv_pkg::xlen_t mtval;
    secv_pkg::xlen_t mip;
    logic            tval_ena;

    // mip mirrors the interrupt lines
    always_comb begin
        mip = '0;
        mip[csr_pkg::IRQ_CAUSE_MEI] = irq_pend_i.mei;
        mip[csr_pkg::IRQ_CAUSE_MTI] = irq_pend_i.mti;
        mip[csr_pkg::IRQ_CAUSE_MSI] = irq_pend_i.msi;
    end

    assign tval_ena = !trap.intr &&
                      (trap.cause == csr_pkg::EX_CAUSE_LOAD_MISALIGNED   ||
                       trap.cause == csr_pkg::EX_CAUSE_LOAD_ACCESS_FAULT ||
                       trap.cause == csr_pkg::EX_CAUSE_STORE_MISALIGNED  ||
                       trap.cause == csr_pkg::EX_CAUSE_STORE_ACCESS_FAULT);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (trap.take) begin
            mepc   <= trap.pc;
            mcause <= {trap.intr, {(secv_pkg::XLEN-6){1'b0}}, trap.cause};
            mtval  <= tval_ena ? trap.tval : '0;
            mstatus[csr_pkg::MSTATUS_MPIE_BIT] <= mstatus[csr_pkg::MSTATUS_MIE_BIT];
            mstatus[csr_pkg::MSTATUS_MIE_BIT]  <= 1'b0;
        end else if (trap.mret) begin
            mstatus[csr_pkg::MSTATUS_MIE_BIT]  <= mstatus[csr_pkg::MSTATUS_MPIE_BIT];
            mstatus[csr_pkg::MSTATUS_MPIE_BIT] <= 1'b1;
        end else if (bus.we) begin
            case (bus.adr)
                csr_pkg::CSR_ADR_MSTATUS:  mstatus  <= bus.wdat & csr_pkg::MSTATUS_MASK;
                csr_pkg::CSR_ADR_MIE:      mie      <= bus.wdat & csr_pkg::MIE_MASK;
                csr_pkg::CSR_ADR_MTVEC:    mtvec    <= bus.wdat & csr_pkg::MTVEC_MASK;
                csr_pkg::CSR_ADR_MSCRATCH: mscratch <= bus.wdat;
                csr_pkg::CSR_ADR_MEPC:     mepc     <= bus.wdat;
                csr_pkg::CSR_ADR_MCAUSE:   mcause   <= bus.wdat;
                csr_pkg::CSR_ADR_MTVAL:    mtval    <= bus.wdat;
                default: ;   // Read-only or not ours
            endcase
        end
    end

    // Base, plus 4 * cause for interrupts in vectored mode
    always_comb begin
        trap.vec = {mtvec[secv_pkg::XLEN-1:2], 2'b00};
        if (mtvec[0] && trap.intr)
            trap.vec = trap.vec + (secv_pkg::xlen_t'(trap.cause) << 2);
    end

    always_comb begin
        bus.hit  = 1'b1;
        bus.rdat = '0;
        case (bus.adr)
            csr_pkg::CSR_ADR_MSTATUS:   bus.rdat = mstatus;
            csr_pkg::CSR_ADR_MISA:      bus.rdat = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_ADR_MIE:       bus.rdat = mie;
            csr_pkg::CSR_ADR_MTVEC:     bus.rdat = mtvec;
            csr_pkg::CSR_ADR_MSCRATCH:  bus.rdat = mscratch;
            csr_pkg::CSR_ADR_MEPC:      bus.rdat = mepc;
            csr_pkg::CSR_ADR_MCAUSE:    bus.rdat = mcause;
            csr_pkg::CSR_ADR_MTVAL:     bus.rdat = mtval;
            csr_pkg::CSR_ADR_MIP:       bus.rdat = mip;
            csr_pkg::CSR_ADR_MVENDORID: bus.rdat = csr_pkg::MVENDORID;
            csr_pkg::CSR_ADR_MARCHID:   bus.rdat = csr_pkg::MARCHID;
            csr_pkg::CSR_ADR_MIMPID:    bus.rdat = csr_pkg::MIMPID;
            csr_pkg::CSR_ADR_MHARTID:   bus.rdat = secv_pkg::xlen_t'(hartid_i);
            default:                    bus.hit  = 1'b0;
        endcase
    end

    assign mepc_o        = mepc;
    assign irq_ena_o     = mstatus[csr_pkg::MSTATUS_MIE_BIT];
    assign irq_vec_o.mei = irq_pend_i.mei & mie[csr_pkg::IRQ_CAUSE_MEI];
    assign irq_vec_o.mti = irq_pend_i.mti & mie[csr_pkg::IRQ_CAUSE_MTI];
    assign irq_vec_o.msi = irq_pend_i.msi & mie[csr_pkg::IRQ_CAUSE_MSI];

endmodule

// File: csr_counters.sv
// Machine cycle and instructions-retired counters with CSR write access
`timescale 1ns/1ps

module csr_counters (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          retire_i,   // One pulse per retired instruction
    csr_access_if.slave   bus
);
    secv_pkg::xlen_t mcycle;
    secv_pkg::xlen_t minstret;
    logic            cyc_wr;
    logic            ret_wr;

    assign cyc_wr = bus.we && (bus.adr == csr_pkg::CSR_ADR_MCYCLE);
    assign ret_wr = bus.we && (bus.adr == csr_pkg::CSR_ADR_MINSTRET);

    // A write wins over the increment
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= cyc_wr ? bus.wdat : mcycle + 1'b1;
            if (ret_wr)
                minstret <= bus.wdat;
            else if (retire_i)
                minstret <= minstret + 1'b1;
        end
    end

    always_comb begin
        bus.hit  = 1'b1;
        bus.rdat = '0;
        case (bus.adr)
            csr_pkg::CSR_ADR_MCYCLE:   bus.rdat = mcycle;
            csr_pkg::CSR_ADR_MINSTRET: bus.rdat = minstret;
            default:                   bus.hit  = 1'b0;
        endcase
    end

endmodule

// File: csr_unit.sv
// Machine-mode CSR unit top level joining arbiter, RMW datapath, registers and counters
`timescale 1ns/1ps

module csr_unit #(
    parameter  int HARTS  = 1,
    localparam int HART_W = (HARTS > 1) ? $clog2(HARTS) : 1
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic [HART_W-1:0]    hartid_i,
    input  logic                 csr_req_i,
    input  secv_pkg::csr_op_t    csr_op_i,
    input  csr_pkg::csr_adr_t    csr_adr_i,
    input  secv_pkg::xlen_t      csr_src_i,
    output logic                 csr_done_o,
    output secv_pkg::xlen_t      csr_rdata_o,
    input  logic                 ex_i,
    input  secv_pkg::ex_cause_t  ex_cause_i,
    input  secv_pkg::xlen_t      trap_pc_i,
    input  secv_pkg::xlen_t      trap_adr_i,
    input  logic                 mret_i,
    input  csr_pkg::ivec_t       irq_pend_i,
    input  logic                 retire_i,
    output logic                 redirect_o,
    output secv_pkg::xlen_t      redirect_pc_o
);
    csr_access_if reg_bus ();
    csr_access_if cnt_bus ();
    trap_if       trap ();

    logic            rmw_go;
    logic            irq_ena;
    csr_pkg::ivec_t  irq_vec;
    secv_pkg::xlen_t mepc;

    csr_trap_fsm u_fsm (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .csr_req_i     (csr_req_i),
        .ex_i          (ex_i),
        .mret_i        (mret_i),
        .ex_cause_i    (ex_cause_i),
        .trap_pc_i     (trap_pc_i),
        .trap_adr_i    (trap_adr_i),
        .irq_ena_i     (irq_ena),
        .irq_vec_i     (irq_vec),
        .rmw_go_o      (rmw_go),
        .trap          (trap.driver),
        .csr_done_o    (csr_done_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o),
        .mepc_i        (mepc)
    );

    csr_rmw u_rmw (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .go_i    (rmw_go),
        .op_i    (csr_op_i),
        .adr_i   (csr_adr_i),
        .src_i   (csr_src_i),
        .reg_bus (reg_bus.master),
        .cnt_bus (cnt_bus.master),
        .rdata_o (csr_rdata_o)
    );

    csr_regs #(
        .HARTS (HARTS)
    ) u_regs (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .hartid_i   (hartid_i),
        .irq_pend_i (irq_pend_i),
        .bus        (reg_bus.slave),
        .trap       (trap.receiver),
        .mepc_o     (mepc),
        .irq_ena_o  (irq_ena),
        .irq_vec_o  (irq_vec)
    );

    csr_counters u_cnt (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .retire_i (retire_i),
        .bus      (cnt_bus.slave)
    );

endmodule

// File: tb_csr_unit.sv
// Self-checking testbench for the CSR unit with a shadow register model and response checker
`timescale 1ns/1ps

module tb_csr_unit;
    localparam int N_RAND = 40;
    localparam int N_EXC  = 8;
    localparam int N_RET  = 12;
    // Roughly three cycles per event plus retire burst and idle gaps
    localparam int PLAN_CYC = 3 * (N_RAND + 6 * N_EXC + 30) + 2 * N_RET + 30;
    localparam int LIMIT    = 2 * PLAN_CYC;

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic [1:0]          hartid_i;
    logic                csr_req_i, ex_i, mret_i, retire_i;
    secv_pkg::csr_op_t   csr_op_i;
    csr_pkg::csr_adr_t   csr_adr_i;
    secv_pkg::xlen_t     csr_src_i, trap_pc_i, trap_adr_i;
    secv_pkg::ex_cause_t ex_cause_i;
    csr_pkg::ivec_t      irq_pend_i;
    logic                csr_done_o, redirect_o;
    secv_pkg::xlen_t     csr_rdata_o, redirect_pc_o;

    int cyc = 0;     // Follows the mcycle rule, also feeds the timeout
    int errors = 0;
    int checks = 0;
    int issue_cyc;
    secv_pkg::xlen_t done_val[$];   // Expected responses and their due cycles
    int              done_cyc[$];
    secv_pkg::xlen_t red_val[$];
    int              red_cyc[$];
    secv_pkg::xlen_t sh_mstatus, sh_mie, sh_mtvec, sh_mscratch;
    secv_pkg::xlen_t sh_mepc, sh_mcause, sh_mtval, sh_minstret;

    csr_unit #(.HARTS(4)) dut0 (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= rst_i ? 0 : cyc + 1;
        if (cyc > LIMIT) begin
            $display("Timeout: no end of test after %0d cycles", LIMIT);
            $display("Summary: %0d checks, %0d errors", checks, errors);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input secv_pkg::xlen_t got,
                               input secv_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got=%h expected=%h", $time, name, got, exp);
        end
    endtask

    // Old value of a CSR access, shadow registers take the new value
    function automatic secv_pkg::xlen_t model_csr(secv_pkg::csr_op_t op, csr_pkg::csr_adr_t adr,
                                                  secv_pkg::xlen_t src, secv_pkg::xlen_t mcycle);
        secv_pkg::xlen_t old;
        secv_pkg::xlen_t nv;
        case (adr)
            csr_pkg::CSR_ADR_MSTATUS:  old = sh_mstatus;
            csr_pkg::CSR_ADR_MISA:     old = 64'h8000_0000_0000_0100;   // RV64I
            csr_pkg::CSR_ADR_MIE:      old = sh_mie;
            csr_pkg::CSR_ADR_MTVEC:    old = sh_mtvec;
            csr_pkg::CSR_ADR_MSCRATCH: old = sh_mscratch;
            csr_pkg::CSR_ADR_MEPC:     old = sh_mepc;
            csr_pkg::CSR_ADR_MCAUSE:   old = sh_mcause;
            csr_pkg::CSR_ADR_MTVAL:    old = sh_mtval;
            csr_pkg::CSR_ADR_MHARTID:  old = 64'd2;
            csr_pkg::CSR_ADR_MCYCLE:   old = mcycle;
            csr_pkg::CSR_ADR_MINSTRET: old = sh_minstret;
            default:                   old = '0;
        endcase
        case (op)
            secv_pkg::CSR_RS: nv = old | src;
            secv_pkg::CSR_RC: nv = old & ~src;
            default:          nv = src;
        endcase
        case (adr)
            csr_pkg::CSR_ADR_MSTATUS:  sh_mstatus  = nv & 64'h88;
            csr_pkg::CSR_ADR_MIE:      sh_mie      = nv & 64'h888;
            csr_pkg::CSR_ADR_MTVEC:    sh_mtvec    = nv & ~64'h2;
            csr_pkg::CSR_ADR_MSCRATCH: sh_mscratch = nv;
            csr_pkg::CSR_ADR_MEPC:     sh_mepc     = nv;
            csr_pkg::CSR_ADR_MCAUSE:   sh_mcause   = nv;
            csr_pkg::CSR_ADR_MTVAL:    sh_mtval    = nv;
            csr_pkg::CSR_ADR_MINSTRET: sh_minstret = nv;
            default: ;
        endcase
        return old;
    endfunction

    // Trap entry, returns the expected vector
    function automatic secv_pkg::xlen_t model_trap(logic intr, secv_pkg::ex_cause_t cause,
                                                   secv_pkg::xlen_t pc, secv_pkg::xlen_t adr);
        secv_pkg::xlen_t vec;
        vec = {sh_mtvec[63:2], 2'b00};
        if (intr && sh_mtvec[0])
            vec = vec + 64'(cause) * 4;
        sh_mepc   = pc;
        sh_mcause = {intr, 58'd0, cause};
        sh_mtval  = (!intr && cause >= 5'd4 && cause <= 5'd7) ? adr : '0;   // Load/store faults
        sh_mstatus[7] = sh_mstatus[3];
        sh_mstatus[3] = 1'b0;
        return vec;
    endfunction

    function automatic secv_pkg::xlen_t model_mret();
        sh_mstatus[3] = sh_mstatus[7];
        sh_mstatus[7] = 1'b1;
        return sh_mepc;
    endfunction

    // Response checker, sampled away from the driving edge
    always @(negedge clk_i) begin
        if (csr_done_o) begin
            if (done_val.size() == 0) begin
                errors++;
                $display("ERROR t=%0t csr_done_o pulsed without a pending request", $time);
            end else begin
                check_value("csr_done_o cycle", cyc, done_cyc.pop_front());
                check_value("csr_rdata_o", csr_rdata_o, done_val.pop_front());
            end
        end
        if (redirect_o) begin
            if (red_val.size() == 0) begin
                errors++;
                $display("ERROR t=%0t redirect_o pulsed without a pending trap or mret", $time);
            end else begin
                check_value("redirect_o cycle", cyc, red_cyc.pop_front());
                check_value("redirect_pc_o", redirect_pc_o, red_val.pop_front());
            end
        end
    end

    task automatic wait_idle();
        while (done_val.size() != 0 || red_val.size() != 0)
            @(posedge clk_i);
    endtask

    task automatic csr_op(input secv_pkg::csr_op_t op, input csr_pkg::csr_adr_t adr,
                          input secv_pkg::xlen_t src);
        @(posedge clk_i);
        issue_cyc = cyc;
        done_val.push_back(model_csr(op, adr, src, cyc + 1));
        done_cyc.push_back(cyc + 2);   // Accepted next edge, done one cycle later
        csr_req_i <= 1'b1;
        csr_op_i  <= op;
        csr_adr_i <= adr;
        csr_src_i <= src;
        @(posedge clk_i);
        csr_req_i <= 1'b0;
    endtask

    task automatic csr_access(input secv_pkg::csr_op_t op, input csr_pkg::csr_adr_t adr,
                              input secv_pkg::xlen_t src);
        csr_op(op, adr, src);
        wait_idle();
    endtask

    task automatic raise_ex(input secv_pkg::ex_cause_t cause, input secv_pkg::xlen_t pc,
                            input secv_pkg::xlen_t adr);
        @(posedge clk_i);
        red_val.push_back(model_trap(1'b0, cause, pc, adr));
        red_cyc.push_back(cyc + 2);
        ex_i       <= 1'b1;
        ex_cause_i <= cause;
        trap_pc_i  <= pc;
        trap_adr_i <= adr;
        @(posedge clk_i);
        ex_i <= 1'b0;
        wait_idle();
    endtask

    task automatic do_mret();
        @(posedge clk_i);
        red_val.push_back(model_mret());
        red_cyc.push_back(cyc + 2);
        mret_i <= 1'b1;
        @(posedge clk_i);
        mret_i <= 1'b0;
        wait_idle();
    endtask

    task automatic retire_burst(input int n);
        logic r;
        repeat (n) begin
            @(posedge clk_i);
            r = $urandom % 2;
            retire_i <= r;
            sh_minstret = sh_minstret + r;
        end
        @(posedge clk_i);
        retire_i <= 1'b0;
    endtask

    task automatic irq_step(input csr_pkg::ivec_t pend, input secv_pkg::irq_cause_t cause);
        secv_pkg::xlen_t irq_pc;
        irq_pc = {$urandom, $urandom} & ~64'h3;
        @(posedge clk_i);
        irq_pend_i <= pend;
        trap_pc_i  <= irq_pc;
        csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MCAUSE, '0);   // mie still clear
        csr_op(secv_pkg::CSR_RW, csr_pkg::CSR_ADR_MSTATUS, 64'h8);
        // Taken in the first idle cycle after the write
        red_val.push_back(model_trap(1'b1, cause, irq_pc, '0));
        red_cyc.push_back(issue_cyc + 4);
        wait_idle();
        irq_pend_i <= '0;
        do_mret();
        csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MSTATUS, '0);
        csr_access(secv_pkg::CSR_RW, csr_pkg::CSR_ADR_MSTATUS, '0);
    endtask

    function automatic csr_pkg::csr_adr_t pick_adr(int i);
        case (i)
            0:       return csr_pkg::CSR_ADR_MSCRATCH;
            1:       return csr_pkg::CSR_ADR_MSTATUS;
            2:       return csr_pkg::CSR_ADR_MIE;
            3:       return csr_pkg::CSR_ADR_MTVEC;
            4:       return csr_pkg::CSR_ADR_MISA;
            5:       return csr_pkg::CSR_ADR_MHARTID;
            default: return 12'h7C0;   // Not implemented
        endcase
    endfunction

    initial begin
        void'($urandom(32'h2980));
        {rst_i, csr_req_i, ex_i, mret_i, retire_i} = 5'b10000;
        hartid_i   = 2'd2;
        csr_op_i   = secv_pkg::CSR_RW;
        csr_adr_i  = '0;
        csr_src_i  = '0;
        ex_cause_i = '0;
        trap_pc_i  = '0;
        trap_adr_i = '0;
        irq_pend_i = '0;
        {sh_mstatus, sh_mie, sh_mtvec, sh_mscratch} = '0;
        {sh_mepc, sh_mcause, sh_mtval, sh_minstret} = '0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;

        repeat (N_RAND)
            csr_access(secv_pkg::csr_op_t'(2'($urandom % 3 + 1)), pick_adr($urandom % 7),
                       {$urandom, $urandom});

        // Exceptions in direct mode
        csr_access(secv_pkg::CSR_RW, csr_pkg::CSR_ADR_MTVEC, {$urandom, $urandom} & ~64'h3);
        for (int i = 0; i < N_EXC; i++) begin
            // Load or store fault on odd passes, any other cause on even ones
            raise_ex((i % 2) ? secv_pkg::ex_cause_t'(4 + $urandom % 4)
                             : secv_pkg::ex_cause_t'(($urandom % 12 + 8) % 16),
                     {$urandom, $urandom}, {$urandom, $urandom});
            csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MEPC, '0);
            csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MCAUSE, '0);
            csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MTVAL, '0);
            do_mret();
            csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MSTATUS, '0);
        end

        // Interrupts in vectored mode
        csr_access(secv_pkg::CSR_RW, csr_pkg::CSR_ADR_MSTATUS, '0);
        csr_access(secv_pkg::CSR_RW, csr_pkg::CSR_ADR_MIE, 64'h888);
        csr_access(secv_pkg::CSR_RW, csr_pkg::CSR_ADR_MTVEC, ({$urandom, $urandom} & ~64'h3) | 1);
        irq_step(3'b111, csr_pkg::IRQ_CAUSE_MEI);
        irq_step(3'b011, csr_pkg::IRQ_CAUSE_MSI);
        irq_step(3'b010, csr_pkg::IRQ_CAUSE_MTI);

        // Counters
        csr_access(secv_pkg::CSR_RW, csr_pkg::CSR_ADR_MINSTRET, {$urandom, $urandom});
        retire_burst(N_RET);
        csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MINSTRET, '0);
        csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MCYCLE, '0);
        repeat ($urandom % 8) @(posedge clk_i);
        csr_access(secv_pkg::CSR_RS, csr_pkg::CSR_ADR_MCYCLE, '0);

        repeat (3) @(posedge clk_i);
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
secv_pkg.sv
csr_pkg.sv
csr_if.sv
csr_trap_fsm.sv
csr_rmw.sv
csr_regs.sv
csr_counters.sv
csr_unit.sv
tb_csr_unit.sv
